// File: include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data path width in bits.
`define XLEN 32

// Architectural register count.
`define REG_COUNT 32

`define EXCCODE_SIZE 5 // Width of the exception code field.

`endif

// File: design/isa_pkg.sv
`include "core_params.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_num_t;

    // Primary opcodes in instr[31:26].
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // Function codes for OP_SPECIAL in instr[5:0].
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        add_wrap, // Sum without overflow check.
        add_trap, // Sum that traps on signed overflow.
        sub_wrap, // Difference without overflow check.
        sub_trap, // Difference that traps on signed overflow.
        op_and,
        op_or,
        op_slt,   // Signed set-less-than.
        op_lui    // Passes the shifted immediate.
    } alu_op_t;

    typedef enum logic [`EXCCODE_SIZE-1:0] {
        exc_none = `EXCCODE_SIZE'd0,
        exc_ri   = `EXCCODE_SIZE'd10, // Reserved instruction.
        exc_ov   = `EXCCODE_SIZE'd12  // Arithmetic overflow.
    } exc_code_t;

endpackage

// File: design/pipe_pkg.sv
`include "core_params.svh"

package pipe_pkg;

    import isa_pkg::*;

    // Decode to execute.
    typedef struct packed {
        word_t     instr;
        word_t     pc8;
        word_t     rs_data;      // Already forwarded.
        word_t     rt_data;
        word_t     ext_result;   // Extended immediate.
        alu_op_t   alu_op;
        logic      use_imm;
        reg_num_t  write_number;
        logic      write_enable;
        exc_code_t exc_code;
        logic      bd;
    } de_payload_t;

    // Execute to writeback.
    typedef struct packed {
        word_t     pc8;
        word_t     result;
        reg_num_t  write_number;
        logic      write_enable;
        exc_code_t exc_code;
        logic      bd;
    } ew_payload_t;

endpackage

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_num_t rs_number,
    input  reg_num_t rt_number,
    input  logic     write_enable,
    input  reg_num_t write_number,
    input  word_t    write_data,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_number != '0) begin
            regs[write_number] <= write_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle.
    always_comb begin
        if (rs_number == '0)
            rs_data = '0;
        else if (write_enable && write_number == rs_number)
            rs_data = write_data;
        else
            rs_data = regs[rs_number];

        if (rt_number == '0)
            rt_data = '0;
        else if (write_enable && write_number == rt_number)
            rt_data = write_data;
        else
            rt_data = regs[rt_number];
    end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t       instr,
    input  word_t       pc8,
    input  logic        bd,
    input  word_t       rs_data,
    input  word_t       rt_data,
    input  logic        fwd_enable,
    input  reg_num_t    fwd_number,
    input  word_t       fwd_data,
    output reg_num_t    rs_number,
    output reg_num_t    rt_number,
    output de_payload_t payload
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    reg_num_t    rd_number;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        illegal;
    reg_num_t    dest;
    word_t       ext_result;

    assign opcode    = instr[31:26];
    assign rs_number = instr[25:21];
    assign rt_number = instr[20:16];
    assign rd_number = instr[15:11];
    assign imm       = instr[15:0];
    assign funct     = instr[5:0];

    always_comb begin
        alu_op     = add_wrap;
        use_imm    = 1'b0;
        illegal    = 1'b0;
        dest       = rd_number;
        ext_result = '0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADD:  alu_op = add_trap;
                    FN_ADDU: alu_op = add_wrap;
                    FN_SUB:  alu_op = sub_trap;
                    FN_SUBU: alu_op = sub_wrap;
                    FN_AND:  alu_op = op_and;
                    FN_OR:   alu_op = op_or;
                    FN_SLT:  alu_op = op_slt;
                    default: illegal = (instr != '0); // All-zero word is the nop.
                endcase
            end
            OP_ADDI, OP_ADDIU: begin
                alu_op     = (opcode == OP_ADDI) ? add_trap : add_wrap;
                use_imm    = 1'b1;
                dest       = rt_number;
                ext_result = {{(`XLEN-16){imm[15]}}, imm}; // Sign extend.
            end
            OP_ORI: begin
                alu_op     = op_or;
                use_imm    = 1'b1;
                dest       = rt_number;
                ext_result = {{(`XLEN-16){1'b0}}, imm};
            end
            OP_LUI: begin
                alu_op     = op_lui;
                use_imm    = 1'b1;
                dest       = rt_number;
                ext_result = {imm, {(`XLEN-16){1'b0}}};
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        payload.instr        = instr;
        payload.pc8          = pc8;
        // Execute result is newer than anything in the register file.
        payload.rs_data      = (fwd_enable && fwd_number == rs_number && rs_number != '0)
                               ? fwd_data : rs_data;
        payload.rt_data      = (fwd_enable && fwd_number == rt_number && rt_number != '0)
                               ? fwd_data : rt_data;
        payload.ext_result   = ext_result;
        payload.alu_op       = alu_op;
        payload.use_imm      = use_imm;
        payload.write_number = dest;
        payload.write_enable = !illegal && dest != '0;
        payload.exc_code     = illegal ? exc_ri : exc_none;
        payload.bd           = bd;
    end

endmodule

// File: design/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Exception request outranks stall, stall outranks flush.
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (req) begin
            q <= '0;
        end else if (stall) begin
            q <= q;
        end else if (flush) begin
            q <= '0; // Bubble.
        end else begin
            q <= d;
        end
    end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  de_payload_t payload,
    output word_t       result,
    output logic        fwd_enable,
    output reg_num_t    fwd_number,
    output ew_payload_t out_payload
);

    word_t a;
    word_t b;
    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;
    logic  trap;

    assign a    = payload.rs_data;
    assign b    = payload.use_imm ? payload.ext_result : payload.rt_data;
    assign sum  = a + b;
    assign diff = a - b;

    // Signed overflow from operand and result signs.
    assign add_ovf = (a[`XLEN-1] == b[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
    assign sub_ovf = (a[`XLEN-1] != b[`XLEN-1]) && (diff[`XLEN-1] != a[`XLEN-1]);

    assign trap = (payload.alu_op == add_trap && add_ovf)
               || (payload.alu_op == sub_trap && sub_ovf);

    always_comb begin
        case (payload.alu_op)
            add_wrap, add_trap: result = sum;
            sub_wrap, sub_trap: result = diff;
            op_and:             result = a & b;
            op_or:              result = a | b;
            op_slt:             result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default:            result = b; // lui
        endcase
    end

    always_comb begin
        out_payload.pc8          = payload.pc8;
        out_payload.result       = result;
        out_payload.write_number = payload.write_number;
        out_payload.write_enable = payload.write_enable && !trap;
        // A decode exception keeps its code.
        if (payload.exc_code != exc_none)
            out_payload.exc_code = payload.exc_code;
        else if (trap)
            out_payload.exc_code = exc_ov;
        else
            out_payload.exc_code = exc_none;
        out_payload.bd           = payload.bd;
    end

    assign fwd_enable = out_payload.write_enable;
    assign fwd_number = payload.write_number;

endmodule

// File: design/de_core.sv
`timescale 1ns/1ps
`include "core_params.svh"

module de_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      req,
    input  logic      stall,
    input  logic      flush,
    input  word_t     instr,
    input  word_t     pc8,
    input  logic      bd,
    output word_t     wb_pc8,
    output word_t     wb_result,
    output reg_num_t  wb_write_number,
    output logic      wb_write_enable,
    output exc_code_t wb_exc_code,
    output logic      wb_bd
);

    reg_num_t    rs_number;
    reg_num_t    rt_number;
    word_t       rs_data;
    word_t       rt_data;
    logic        fwd_enable;
    reg_num_t    fwd_number;
    word_t       fwd_data;
    de_payload_t de_d;
    de_payload_t de_q;
    ew_payload_t ew_d;
    ew_payload_t ew_q;
    logic        rf_write_enable;

    decode_stage u_decode (
        .instr      (instr),
        .pc8        (pc8),
        .bd         (bd),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .fwd_enable (fwd_enable),
        .fwd_number (fwd_number),
        .fwd_data   (fwd_data),
        .rs_number  (rs_number),
        .rt_number  (rt_number),
        .payload    (de_d)
    );

    stage_reg #(.payload_t(de_payload_t)) de_reg (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .stall (stall),
        .flush (flush),
        .d     (de_d),
        .q     (de_q)
    );

    execute_stage u_execute (
        .payload     (de_q),
        .result      (fwd_data),
        .fwd_enable  (fwd_enable),
        .fwd_number  (fwd_number),
        .out_payload (ew_d)
    );

    // Flush only bubbles the execute entry.
    stage_reg #(.payload_t(ew_payload_t)) ew_reg (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .stall (stall),
        .flush (1'b0),
        .d     (ew_d),
        .q     (ew_q)
    );

    assign rf_write_enable = ew_q.write_enable && ew_q.exc_code == exc_none;

    reg_file u_reg_file (
        .clk          (clk),
        .reset        (reset),
        .rs_number    (rs_number),
        .rt_number    (rt_number),
        .write_enable (rf_write_enable),
        .write_number (ew_q.write_number),
        .write_data   (ew_q.result),
        .rs_data      (rs_data),
        .rt_data      (rt_data)
    );

    assign wb_pc8          = ew_q.pc8;
    assign wb_result       = ew_q.result;
    assign wb_write_number = ew_q.write_number;
    assign wb_write_enable = ew_q.write_enable;
    assign wb_exc_code     = ew_q.exc_code;
    assign wb_bd           = ew_q.bd;

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    // Reset covers the first four rising edges.
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: test/de_core_tb.sv
`timescale 1ns/1ps
`include "core_params.svh"

module de_core_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    logic      clk;
    logic      reset;
    logic      req;
    logic      stall;
    logic      flush;
    logic      bd;
    word_t     instr;
    word_t     pc8;
    word_t     wb_pc8;
    word_t     wb_result;
    reg_num_t  wb_write_number;
    logic      wb_write_enable;
    exc_code_t wb_exc_code;
    logic      wb_bd;

    word_t       shadow [`REG_COUNT]; // Architectural state of the model.
    logic [31:0] lfsr_state = 32'hff72b248;
    ew_payload_t pending [$];
    string       names [$];
    word_t       next_pc;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    de_core uut (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .stall           (stall),
        .flush           (flush),
        .instr           (instr),
        .pc8             (pc8),
        .bd              (bd),
        .wb_pc8          (wb_pc8),
        .wb_result       (wb_result),
        .wb_write_number (wb_write_number),
        .wb_write_enable (wb_write_enable),
        .wb_exc_code     (wb_exc_code),
        .wb_bd           (wb_bd)
    );

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t r_type(input logic [5:0] fn, input reg_num_t rs,
                                     input reg_num_t rt, input reg_num_t rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_num_t rs,
                                     input reg_num_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic fits32(input longint v);
        return v == longint'($signed(v[31:0]));
    endfunction

    function automatic word_t new_pc();
        next_pc = next_pc + 4;
        return next_pc + 8;
    endfunction

    // Random operation reading rs and writing dst.
    function automatic word_t random_op(input reg_num_t rs, input reg_num_t dst);
        logic [31:0] sel;
        logic [31:0] rt;
        logic [31:0] imm;
        word_t       ins;
        sel = take_bits(4);
        rt  = 1 + take_bits(3);
        imm = take_bits(16);
        case (sel)
            0:       ins = r_type(FN_ADD, rs, rt[4:0], dst);
            1:       ins = r_type(FN_ADDU, rs, rt[4:0], dst);
            2:       ins = r_type(FN_SUB, rs, rt[4:0], dst);
            3:       ins = r_type(FN_SUBU, rs, rt[4:0], dst);
            4:       ins = r_type(FN_AND, rs, rt[4:0], dst);
            5:       ins = r_type(FN_OR, rs, rt[4:0], dst);
            6:       ins = r_type(FN_SLT, rs, rt[4:0], dst);
            7:       ins = i_type(OP_ADDI, rs, dst, imm[15:0]);
            8:       ins = i_type(OP_ADDIU, rs, dst, imm[15:0]);
            9:       ins = i_type(OP_ORI, rs, dst, imm[15:0]);
            default: ins = i_type(OP_LUI, rs, dst, imm[15:0]);
        endcase
        return ins;
    endfunction

    function automatic reg_num_t random_dest();
        logic [31:0] d;
        d = take_bits(5);
        return (d[4:0] == 0) ? reg_num_t'(1) : d[4:0];
    endfunction

    // Reference model in program order; commits to the shadow registers.
    task automatic predict(input word_t ins, input word_t pc, input logic b,
                           output ew_payload_t e);
        logic [5:0] op;
        logic [5:0] fn;
        word_t      a;
        word_t      t;
        word_t      imm_s;
        logic       ovf;
        logic       known;
        op    = ins[31:26];
        fn    = ins[5:0];
        a     = shadow[ins[25:21]];
        t     = shadow[ins[20:16]];
        imm_s = {{16{ins[15]}}, ins[15:0]};
        ovf   = 1'b0;
        known = 1'b1;
        e     = '0;
        e.pc8 = pc;
        e.bd  = b;
        e.write_number = ins[15:11];
        e.result = a + t; // Undecoded words still pass rs plus rt.
        if (op == OP_SPECIAL) begin
            case (fn)
                FN_ADD, FN_ADDU: e.result = a + t;
                FN_SUB, FN_SUBU: e.result = a - t;
                FN_AND:          e.result = a & t;
                FN_OR:           e.result = a | t;
                FN_SLT:          e.result = ($signed(a) < $signed(t)) ? 32'd1 : 32'd0;
                default:         known = (ins == '0);
            endcase
            if (fn == FN_ADD)
                ovf = !fits32(longint'($signed(a)) + longint'($signed(t)));
            if (fn == FN_SUB)
                ovf = !fits32(longint'($signed(a)) - longint'($signed(t)));
        end else if (op == OP_ADDI || op == OP_ADDIU) begin
            e.write_number = ins[20:16];
            e.result = a + imm_s;
            if (op == OP_ADDI)
                ovf = !fits32(longint'($signed(a)) + longint'($signed(imm_s)));
        end else if (op == OP_ORI) begin
            e.write_number = ins[20:16];
            e.result = a | {16'h0, ins[15:0]};
        end else if (op == OP_LUI) begin
            e.write_number = ins[20:16];
            e.result = {ins[15:0], 16'h0};
        end else begin
            known = 1'b0;
        end
        if (!known)
            e.exc_code = exc_ri;
        else if (ovf)
            e.exc_code = exc_ov;
        else
            e.exc_code = exc_none;
        e.write_enable = known && !ovf && e.write_number != 0;
        if (e.write_enable)
            shadow[e.write_number] = e.result;
    endtask

    task automatic stop_on_error();
        $display("sim failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_number(input string name, input reg_num_t exp,
                                input reg_num_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_exc(input string name, input exc_code_t exp, input exc_code_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %s (%0d), actual %s (%0d)",
                     name, exp.name(), exp, act.name(), act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bundle(input string name, input ew_payload_t e);
        check_word({name, " pc8"}, e.pc8, wb_pc8);
        check_word({name, " result"}, e.result, wb_result);
        check_number({name, " write_number"}, e.write_number, wb_write_number);
        check_bit({name, " write_enable"}, e.write_enable, wb_write_enable);
        check_exc({name, " exc_code"}, e.exc_code, wb_exc_code);
        check_bit({name, " bd"}, e.bd, wb_bd);
    endtask

    // Inputs change and outputs are sampled 1 ns after the edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic present(input word_t ins, input word_t pc, input logic b);
        instr = ins;
        pc8   = pc;
        bd    = b;
    endtask

    // Issues one instruction; the one before it reaches writeback at this edge.
    task automatic issue(input string name, input word_t ins);
        ew_payload_t e;
        logic [31:0] b;
        word_t       pc;
        b  = take_bits(1);
        pc = new_pc();
        predict(ins, pc, b[0], e);
        pending.push_back(e);
        names.push_back(name);
        present(ins, pc, b[0]);
        step();
        if (pending.size() > 1)
            check_bundle(names.pop_front(), pending.pop_front());
    endtask

    task automatic drain();
        issue("nop", '0);
        issue("nop", '0);
        pending.delete();
        names.delete();
    endtask

    task automatic wait_for_pc(input string name, input word_t pc, output int edges);
        edges = 0;
        while (wb_pc8 !== pc) begin
            if (edges == 8) begin
                $display("Timeout: %s never reached the writeback ports.", name);
                stop_on_error();
            end
            step();
            edges++;
        end
    endtask

    task automatic test_reset();
        int          n;
        ew_payload_t z;
        n = 0;
        z = '0;
        @(posedge clk);
        while (reset) begin
            if (n == 20) begin
                $display("Timeout: reset was never released.");
                stop_on_error();
            end
            @(posedge clk);
            n++;
        end
        #1;
        check_bundle("reset", z);
    endtask

    task automatic test_alu();
        word_t v;
        for (int r = 1; r <= 8; r++) begin
            v = take_bits(32);
            issue("alu_lui", i_type(OP_LUI, 0, reg_num_t'(r), v[31:16]));
            issue("alu_ori", i_type(OP_ORI, reg_num_t'(r), reg_num_t'(r), v[15:0]));
        end
        for (int i = 0; i < 24; i++) begin
            v = 1 + take_bits(3);
            issue("alu_random", random_op(v[4:0], random_dest()));
        end
        drain();
    endtask

    task automatic test_dependences();
        reg_num_t prev;
        reg_num_t dst;
        prev = 1;
        for (int i = 0; i < 24; i++) begin
            dst = random_dest();
            issue("dependence", random_op(prev, dst));
            prev = dst;
        end
        drain();
    endtask

    task automatic test_exceptions();
        issue("exc_setup", i_type(OP_LUI, 0, 1, 16'h7fff));
        issue("exc_setup", i_type(OP_ORI, 1, 1, 16'hffff));
        issue("exc_setup", i_type(OP_ORI, 0, 2, 16'h0001));
        issue("add_overflow", r_type(FN_ADD, 1, 2, 3));
        issue("addi_overflow", i_type(OP_ADDI, 1, 4, 16'h0001));
        issue("read_after_add", r_type(FN_OR, 3, 0, 5));
        issue("read_after_addi", r_type(FN_OR, 4, 0, 6));
        issue("addu_wrap", r_type(FN_ADDU, 1, 2, 7));
        issue("reserved_opcode", {6'h3f, 26'h0123456});
        issue("reserved_funct", r_type(6'h3f, 1, 2, 8));
        drain();
    endtask

    task automatic test_flush();
        ew_payload_t z;
        z = '0;
        issue("before_flush", i_type(OP_ORI, 0, 15, 16'h0f0f));
        present(i_type(OP_ORI, 0, 9, 16'h5a5a), new_pc(), 1'b1);
        flush = 1'b1;
        step();
        check_bundle(names.pop_front(), pending.pop_front()); // Older entry moves on.
        flush = 1'b0;
        present('0, '0, 1'b0);
        step();
        check_bundle("flush_bubble", z);
        issue("read_after_flush", r_type(FN_OR, 9, 0, 10));
        drain();
    endtask

    task automatic test_req();
        ew_payload_t z;
        z = '0;
        present(i_type(OP_LUI, 0, 11, 16'h1234), new_pc(), 1'b1);
        step();
        present(i_type(OP_LUI, 0, 12, 16'h5678), new_pc(), 1'b0);
        req = 1'b1;
        step();
        check_bundle("req_older", z);
        req = 1'b0;
        present('0, '0, 1'b0);
        step();
        check_bundle("req_younger", z);
        issue("read_after_req", r_type(FN_OR, 11, 0, 13));
        issue("read_after_req", r_type(FN_OR, 12, 0, 14));
        drain();
    endtask

    task automatic test_stall();
        ew_payload_t ea;
        ew_payload_t eb;
        ew_payload_t ec;
        ew_payload_t z;
        word_t       ia;
        word_t       ib;
        word_t       ic;
        reg_num_t    da;
        reg_num_t    db;
        int          edges;
        z  = '0;
        da = random_dest();
        db = random_dest();
        ia = random_op(2, da);
        ib = random_op(da, db);
        ic = random_op(db, random_dest());
        predict(ia, new_pc(), 1'b0, ea);
        predict(ib, new_pc(), 1'b1, eb);
        predict(ic, new_pc(), 1'b0, ec);
        present(ia, ea.pc8, ea.bd);
        step();
        present(ib, eb.pc8, eb.bd);
        step();
        check_bundle("stall_first", ea);
        stall = 1'b1;
        present(ic, ec.pc8, ec.bd);
        for (int i = 0; i < 3; i++) begin
            step();
            check_bundle("stall_hold", ea);
        end
        stall = 1'b0;
        wait_for_pc("stall_held", eb.pc8, edges);
        check_word("stall_release_edges", word_t'(1), word_t'(edges));
        check_bundle("stall_held", eb);
        present('0, '0, 1'b0);
        step();
        check_bundle("stall_successor", ec);
        step();
        check_bundle("stall_after", z); // Successor shows only once.
    endtask

    initial begin
        req   = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        present('0, '0, 1'b0);
        next_pc = 32'h0040_0000;
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        test_reset();
        test_alu();
        test_dependences();
        test_exceptions();
        test_flush();
        test_req();
        test_stall();
        $display("sim passed");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/stage_reg.sv
design/execute_stage.sv
design/de_core.sv
test/tb_clock.sv
test/de_core_tb.sv

// File: Bender.yml
package:
  name: de_core

sources:
  - include_dirs:
      - include
    files:
      - design/isa_pkg.sv
      - design/pipe_pkg.sv
      - design/reg_file.sv
      - design/decode_stage.sv
      - design/stage_reg.sv
      - design/execute_stage.sv
      - design/de_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clock.sv
      - test/de_core_tb.sv
